// File: include/mix_consts.svh
`ifndef MIX_CONSTS_SVH
`define MIX_CONSTS_SVH

// --------------------------------------------------
// vector and word geometry
// --------------------------------------------------
`define MIX_HID_DIM 16
`define MIX_DATA_N 4
`define MIX_CHUNKS (`MIX_HID_DIM / `MIX_DATA_N)

// signed Q8.8 for activations, errors, weights and gradients
`define MIX_N_LEN 16
`define MIX_N_LEN_W 16
`define MIX_FRAC 8

// --------------------------------------------------
// memory layout, three layers back to back
// --------------------------------------------------
`define MIX_LAYER_WORDS (`MIX_HID_DIM * `MIX_CHUNKS)
`define MIX_DEPTH (3 * `MIX_LAYER_WORDS)
`define MIX_ADDR_W 8

`endif

// File: logic/mix_pkg.sv
`default_nettype none

`include "mix_consts.svh"

package mix_pkg;

  // single elements
  typedef logic [`MIX_N_LEN-1:0] act_t;
  typedef logic [`MIX_N_LEN_W-1:0] wgt_t;

  // vectors and slices, element n at bits 16n upward
  typedef logic [`MIX_HID_DIM*`MIX_N_LEN-1:0] vec_t;
  typedef logic [`MIX_DATA_N*`MIX_N_LEN-1:0] chunk_t;
  typedef logic [`MIX_DATA_N*`MIX_N_LEN_W-1:0] word_t;

  typedef logic [`MIX_ADDR_W-1:0] addr_t;

  // layer select for a backward run
  typedef enum logic [1:0] {
    LAYER_MIX1 = 2'd0,
    LAYER_MIX2 = 2'd1,
    LAYER_MIX3 = 2'd2
  } layer_t;

endpackage

`default_nettype wire

// File: logic/weight_ram.sv
`default_nettype none

`include "mix_consts.svh"

module weight_ram import mix_pkg::*; (
  input  wire        clk,
  input  wire        w_we,
  input  wire addr_t w_addr,
  input  wire word_t w_wdata,
  input  wire addr_t raddr,
  output word_t      rdata
);

  // all three layers, four weights per word
  word_t mem [`MIX_DEPTH];

  // --------------------------------------------------
  // external load port
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (w_we) begin
      mem[w_addr] <= w_wdata;
    end
  end

  // one cycle read latency
  always_ff @(posedge clk) begin
    rdata <= mem[raddr];
  end

endmodule

`default_nettype wire

// File: logic/grad_ram.sv
`default_nettype none

`include "mix_consts.svh"

module grad_ram import mix_pkg::*; (
  input  wire        clk,
  input  wire        rst_n,
  input  wire        we,
  input  wire addr_t waddr,
  input  wire word_t wdata,
  input  wire addr_t raddr_a,
  output word_t      rdata_a,
  input  wire addr_t raddr_b,
  output word_t      rdata_b
);

  // gradient words, same layout as the weights
  word_t mem [`MIX_DEPTH];

  // --------------------------------------------------
  // write port, whole store starts at zero
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `MIX_DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // --------------------------------------------------
  // registered read ports
  // --------------------------------------------------

  // port a feeds the accumulator
  always_ff @(posedge clk) begin
    rdata_a <= mem[raddr_a];
  end

  // port b is the external readout
  always_ff @(posedge clk) begin
    rdata_b <= mem[raddr_b];
  end

endmodule

`default_nettype wire

// File: logic/mix_dot.sv
`default_nettype none

`include "mix_consts.svh"

module mix_dot import mix_pkg::*; (
  input  wire         clk,
  input  wire         rst_n,
  input  wire         run,
  input  wire chunk_t d,
  input  wire word_t  rdata_w,
  output logic        valid,
  output vec_t        q
);

  localparam int CW = $clog2(`MIX_CHUNKS);
  localparam int WCNT_W = $clog2(`MIX_LAYER_WORDS);
  localparam int PROD_W = `MIX_N_LEN + `MIX_N_LEN_W;
  localparam int VEC_W = $bits(vec_t);

  logic              run_d;
  logic [WCNT_W-1:0] wcnt;
  logic              row_end;
  logic              last_word;

  wgt_t word_sum;
  wgt_t acc;
  wgt_t row_sum;
  vec_t q_sh;

  // --------------------------------------------------
  // four lane products of one word
  // --------------------------------------------------
  always_comb begin : lane_mac
    logic signed [PROD_W-1:0] prod;
    logic signed [PROD_W-1:0] prod_sh;
    word_sum = '0;
    for (int k = 0; k < `MIX_DATA_N; k++) begin
      prod = $signed(d[k*`MIX_N_LEN +: `MIX_N_LEN])
           * $signed(rdata_w[k*`MIX_N_LEN_W +: `MIX_N_LEN_W]);
      prod_sh = prod >>> `MIX_FRAC;
      // back to Q8.8, wraps
      word_sum = word_sum + prod_sh[`MIX_N_LEN_W-1:0];
    end
  end

  // restart the row on its first chunk
  assign row_sum   = (wcnt[CW-1:0] == '0) ? word_sum : acc + word_sum;
  assign row_end   = (wcnt[CW-1:0] == CW'(`MIX_CHUNKS - 1));
  assign last_word = (wcnt == WCNT_W'(`MIX_LAYER_WORDS - 1));

  // --------------------------------------------------
  // control, run delayed to meet the read data
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      run_d <= 1'b0;
      wcnt  <= '0;
      valid <= 1'b0;
    end else begin
      run_d <= run;
      valid <= run_d && last_word;
      if (run_d) begin
        wcnt <= wcnt + 1'b1;
      end else begin
        wcnt <= '0;
      end
    end
  end

  // --------------------------------------------------
  // row accumulator and output shift
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (run_d) begin
      acc <= row_sum;
      // finished rows enter at the top, row 0 ends up in the low bits
      if (row_end) begin
        q_sh <= {row_sum, q_sh[VEC_W-1:`MIX_N_LEN]};
      end
      // q only changes when row 15 lands
      if (last_word) begin
        q <= {row_sum, q_sh[VEC_W-1:`MIX_N_LEN]};
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/grad_accum.sv
`default_nettype none

`include "mix_consts.svh"

module grad_accum import mix_pkg::*; (
  input  wire         clk,
  input  wire         rst_n,
  input  wire         en,
  input  wire addr_t  addr_in,
  input  wire act_t   d_b,
  input  wire chunk_t d_f,
  input  wire word_t  rdata_grad,
  output addr_t       waddr,
  output word_t       wdata,
  output logic        we
);

  localparam int PROD_W = `MIX_N_LEN + `MIX_N_LEN;
  localparam int W = `MIX_N_LEN_W;

  // operands held while the gradient read is in flight
  act_t   b_q;
  chunk_t f_q;

  // --------------------------------------------------
  // stage 1
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      we <= 1'b0;
    end else begin
      we <= en;
    end
  end

  always_ff @(posedge clk) begin
    waddr <= addr_in;
    b_q   <= d_b;
    f_q   <= d_f;
  end

  // --------------------------------------------------
  // stage 2, old word plus outer product lanes
  // --------------------------------------------------
  always_comb begin : lane_update
    logic signed [PROD_W-1:0] prod;
    logic signed [PROD_W-1:0] prod_sh;
    wdata = '0;
    for (int k = 0; k < `MIX_DATA_N; k++) begin
      prod = $signed(b_q) * $signed(f_q[k*`MIX_N_LEN +: `MIX_N_LEN]);
      prod_sh = prod >>> `MIX_FRAC;
      // wraps on overflow
      wdata[k*W +: W] = rdata_grad[k*W +: W] + prod_sh[W-1:0];
    end
  end

endmodule

`default_nettype wire

// File: logic/mix_backward.sv
`default_nettype none

`include "mix_consts.svh"

module mix_backward import mix_pkg::*; (
  input  wire         clk,
  input  wire         rst_n,
  input  wire         run,
  input  wire layer_t layer,
  input  wire vec_t   d_forward,
  input  wire vec_t   d_backward,
  output wire         valid,
  output wire vec_t   q,
  output addr_t       raddr_w,
  input  wire word_t  rdata_w,
  output addr_t       raddr_grad,
  input  wire word_t  rdata_grad,
  output wire addr_t  waddr_grad,
  output wire word_t  wdata_grad,
  output wire         grad_we
);

  localparam int CW = $clog2(`MIX_CHUNKS);
  localparam int RW = $clog2(`MIX_HID_DIM);
  localparam int CHUNK_W = $bits(chunk_t);

  // chunk and row position inside the current layer
  logic [CW-1:0] count;
  logic [RW-1:0] row;

  // operands for the engines
  chunk_t dot_d;
  act_t   ga_d_b;
  chunk_t ga_d_f;

  // first word of each layer
  function automatic addr_t layer_base(layer_t sel);
    case (sel)
      LAYER_MIX2: return addr_t'(`MIX_LAYER_WORDS);
      LAYER_MIX3: return addr_t'(2 * `MIX_LAYER_WORDS);
      default:    return '0;
    endcase
  endfunction

  // --------------------------------------------------
  // sequencer
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count   <= '0;
      row     <= '0;
      dot_d   <= '0;
      raddr_w <= '0;
    end else if (run) begin
      count <= count + 1'b1;
      if (count == CW'(`MIX_CHUNKS - 1)) begin
        row <= row + 1'b1;
      end
      // lines up with rdata_w one cycle later
      dot_d   <= d_backward[count*CHUNK_W +: CHUNK_W];
      raddr_w <= raddr_w + 1'b1;
    end else begin
      count   <= '0;
      row     <= '0;
      dot_d   <= '0;
      // park on the layer base so the first word is ready
      raddr_w <= layer_base(layer);
    end
  end

  // gradient layout matches the weight layout word for word
  assign raddr_grad = raddr_w;

  // error element of the current row, forward slice of the current chunk
  assign ga_d_b = d_backward[row*`MIX_N_LEN +: `MIX_N_LEN];
  assign ga_d_f = d_forward[count*CHUNK_W +: CHUNK_W];

  // --------------------------------------------------
  // engines
  // --------------------------------------------------
  mix_dot u_mix_dot (
    .clk     (clk),
    .rst_n   (rst_n),
    .run     (run),
    .d       (dot_d),
    .rdata_w (rdata_w),
    .valid   (valid),
    .q       (q)
  );

  grad_accum u_grad_accum (
    .clk        (clk),
    .rst_n      (rst_n),
    .en         (run),
    .addr_in    (raddr_grad),
    .d_b        (ga_d_b),
    .d_f        (ga_d_f),
    .rdata_grad (rdata_grad),
    .waddr      (waddr_grad),
    .wdata      (wdata_grad),
    .we         (grad_we)
  );

endmodule

`default_nettype wire

// File: logic/mix_train_top.sv
`default_nettype none

module mix_train_top import mix_pkg::*; (
  input  wire         clk,
  input  wire         rst_n,

  // run control
  input  wire         run,
  input  wire layer_t layer,
  input  wire vec_t   d_forward,
  input  wire vec_t   d_backward,
  output wire         valid,
  output wire vec_t   q,

  // weight load
  input  wire         w_we,
  input  wire addr_t  w_addr,
  input  wire word_t  w_wdata,

  // gradient readout
  input  wire addr_t  g_raddr,
  output wire word_t  g_rdata
);

  // --------------------------------------------------
  // memory side nets
  // --------------------------------------------------
  addr_t raddr_w;
  word_t rdata_w;
  addr_t raddr_grad;
  word_t rdata_grad;
  addr_t waddr_grad;
  word_t wdata_grad;
  logic  grad_we;

  weight_ram u_weight_ram (
    .clk     (clk),
    .w_we    (w_we),
    .w_addr  (w_addr),
    .w_wdata (w_wdata),
    .raddr   (raddr_w),
    .rdata   (rdata_w)
  );

  grad_ram u_grad_ram (
    .clk     (clk),
    .rst_n   (rst_n),
    .we      (grad_we),
    .waddr   (waddr_grad),
    .wdata   (wdata_grad),
    .raddr_a (raddr_grad),
    .rdata_a (rdata_grad),
    .raddr_b (g_raddr),
    .rdata_b (g_rdata)
  );

  // --------------------------------------------------
  // backward pass
  // --------------------------------------------------
  mix_backward u_mix_backward (
    .clk        (clk),
    .rst_n      (rst_n),
    .run        (run),
    .layer      (layer),
    .d_forward  (d_forward),
    .d_backward (d_backward),
    .valid      (valid),
    .q          (q),
    .raddr_w    (raddr_w),
    .rdata_w    (rdata_w),
    .raddr_grad (raddr_grad),
    .rdata_grad (rdata_grad),
    .waddr_grad (waddr_grad),
    .wdata_grad (wdata_grad),
    .grad_we    (grad_we)
  );

endmodule

`default_nettype wire

// File: tb/mix_train_tb.sv
`default_nettype none

`include "mix_consts.svh"

module mix_train_tb import mix_pkg::*; ();

  localparam int RUN_WORDS = `MIX_LAYER_WORDS;
  localparam int ELEM_W = `MIX_N_LEN;
  // reset, weight load, three readouts of two cycles a word, five runs, doubled
  localparam int WATCH_CYCLES =
    2 * (2 + `MIX_DEPTH + 2 + 3 * 2 * `MIX_DEPTH + 5 * 70);

  logic   clk;
  logic   rst_n;
  logic   run;
  layer_t layer;
  vec_t   d_forward;
  vec_t   d_backward;
  logic   valid;
  vec_t   q;
  logic   w_we;
  addr_t  w_addr;
  word_t  w_wdata;
  addr_t  g_raddr;
  word_t  g_rdata;

  // reference copies of both memories
  word_t wmodel [`MIX_DEPTH];
  word_t gmodel [`MIX_DEPTH];

  // expected q per run, oldest first
  vec_t  q_expect [$];
  string q_name [$];

  integer seed = 24556;
  int     checks = 0;
  int     mismatches = 0;
  int     failures = 0;

  mix_train_top UUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .run        (run),
    .layer      (layer),
    .d_forward  (d_forward),
    .d_backward (d_backward),
    .valid      (valid),
    .q          (q),
    .w_we       (w_we),
    .w_addr     (w_addr),
    .w_wdata    (w_wdata),
    .g_raddr    (g_raddr),
    .g_rdata    (g_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // --------------------------------------------------
  // reference model
  // --------------------------------------------------

  // Q8.8 product, floored by the fraction bits, wrapped to 16
  function automatic wgt_t fx_mul(logic [15:0] a, logic [15:0] b);
    int sa;
    int sb;
    sa = 32'($signed(a));
    sb = 32'($signed(b));
    return wgt_t'((sa * sb) >>> `MIX_FRAC);
  endfunction

  function automatic vec_t model_q(layer_t sel, vec_t d_b);
    vec_t  r;
    wgt_t  sum;
    word_t w;
    int    base;
    base = int'(sel) * `MIX_LAYER_WORDS;
    r = '0;
    for (int i = 0; i < `MIX_HID_DIM; i++) begin
      sum = '0;
      for (int c = 0; c < `MIX_HID_DIM; c++) begin
        w = wmodel[base + i * `MIX_CHUNKS + c / `MIX_DATA_N];
        sum = sum + fx_mul(w[(c % `MIX_DATA_N) * ELEM_W +: ELEM_W],
                           d_b[c * ELEM_W +: ELEM_W]);
      end
      r[i * ELEM_W +: ELEM_W] = sum;
    end
    return r;
  endfunction

  // outer product d_b x d_f added onto the layer's gradient block
  function automatic void model_grad(layer_t sel, vec_t d_f, vec_t d_b);
    int a;
    int lane;
    for (int i = 0; i < `MIX_HID_DIM; i++) begin
      for (int c = 0; c < `MIX_HID_DIM; c++) begin
        a = int'(sel) * `MIX_LAYER_WORDS + i * `MIX_CHUNKS + c / `MIX_DATA_N;
        lane = (c % `MIX_DATA_N) * ELEM_W;
        gmodel[a][lane +: ELEM_W] = gmodel[a][lane +: ELEM_W]
          + fx_mul(d_b[i * ELEM_W +: ELEM_W], d_f[c * ELEM_W +: ELEM_W]);
      end
    end
  endfunction

  // --------------------------------------------------
  // stimulus helpers
  // --------------------------------------------------
  task automatic rand_vec(output vec_t v);
    for (int n = 0; n < `MIX_HID_DIM; n++) begin
      v[n * ELEM_W +: ELEM_W] = act_t'($random(seed));
    end
  endtask

  task automatic load_weights();
    word_t w;
    for (int a = 0; a < `MIX_DEPTH; a++) begin
      w = {$random(seed), $random(seed)};
      wmodel[a] = w;
      @(posedge clk);
      #1;
      w_we = 1'b1;
      w_addr = addr_t'(a);
      w_wdata = w;
    end
    @(posedge clk);
    #1;
    w_we = 1'b0;
  endtask

  // operands go out one cycle ahead of run, run stays high for one layer
  task automatic start_run(string name, layer_t sel);
    vec_t db;
    vec_t df;
    rand_vec(db);
    rand_vec(df);
    layer = sel;
    d_backward = db;
    d_forward = df;
    q_expect.push_back(model_q(sel, db));
    q_name.push_back(name);
    model_grad(sel, df, db);
    @(posedge clk);
    #1;
    run = 1'b1;
    repeat (RUN_WORDS) @(posedge clk);
    #1;
    run = 1'b0;
  endtask

  task automatic wait_runs();
    while (q_expect.size() != 0) begin
      @(posedge clk);
    end
    repeat (2) @(posedge clk);
    #1;
  endtask

  task automatic check_grads(string name);
    for (int a = 0; a < `MIX_DEPTH; a++) begin
      g_raddr = addr_t'(a);
      @(posedge clk);
      @(negedge clk);
      checks++;
      assert (g_rdata == gmodel[a]) else begin
        mismatches++;
        $display("MISMATCH %s addr %0d expected %h actual %h",
                 name, a, gmodel[a], g_rdata);
      end
      @(posedge clk);
      #1;
    end
  endtask

  // --------------------------------------------------
  // checks on q and on valid timing
  // --------------------------------------------------
  always @(negedge clk) begin : q_check
    vec_t  exp_q;
    string name;
    if (rst_n && valid) begin
      if (q_expect.size() == 0) begin
        failures++;
        $display("valid pulsed with no run outstanding");
      end else begin
        exp_q = q_expect.pop_front();
        name = q_name.pop_front();
        for (int i = 0; i < `MIX_HID_DIM; i++) begin
          checks++;
          assert (q[i * ELEM_W +: ELEM_W] == exp_q[i * ELEM_W +: ELEM_W]) else begin
            mismatches++;
            $display("MISMATCH %s q[%0d] expected %h actual %h", name, i,
                     exp_q[i * ELEM_W +: ELEM_W], q[i * ELEM_W +: ELEM_W]);
          end
        end
      end
    end
  end

  // valid comes two cycles after the last run cycle
  assert property (@(posedge clk) disable iff (!rst_n) $fell(run) |=> valid)
    else begin
      failures++;
      $display("valid did not follow the end of a run");
    end

  assert property (@(posedge clk) disable iff (!rst_n) valid |=> !valid)
    else begin
      failures++;
      $display("valid stayed high for more than one cycle");
    end

  assert property (@(posedge clk) disable iff (!rst_n)
                   valid |-> ($past(run, 2) && !$past(run)))
    else begin
      failures++;
      $display("valid pulsed outside its slot after a run");
    end

  // --------------------------------------------------
  // test sequence
  // --------------------------------------------------
  initial begin : stimulus
    rst_n = 1'b0;
    run = 1'b0;
    layer = LAYER_MIX1;
    d_forward = '0;
    d_backward = '0;
    w_we = 1'b0;
    w_addr = '0;
    w_wdata = '0;
    g_raddr = '0;
    for (int a = 0; a < `MIX_DEPTH; a++) begin
      gmodel[a] = '0;
    end
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    checks++;
    assert (valid == 1'b0) else begin
      failures++;
      $display("valid was high right after reset");
    end
    check_grads("reset_clear");

    load_weights();
    start_run("mix1_first", LAYER_MIX1);
    wait_runs();
    check_grads("mix1_single");

    // back to back, one idle cycle between runs
    start_run("mix2_first", LAYER_MIX2);
    start_run("mix3_only", LAYER_MIX3);
    start_run("mix1_second", LAYER_MIX1);
    start_run("mix2_second", LAYER_MIX2);
    wait_runs();
    check_grads("grad_sum");

    $display("checks %0d, mismatches %0d, other errors %0d",
             checks, mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (WATCH_CYCLES) @(posedge clk);
    $display("timeout, the test sequence did not finish within %0d cycles", WATCH_CYCLES);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
+incdir+include
logic/mix_pkg.sv
logic/weight_ram.sv
logic/grad_ram.sv
logic/mix_dot.sv
logic/grad_accum.sv
logic/mix_backward.sv
logic/mix_train_top.sv
tb/mix_train_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TB_TOP     := mix_train_tb
RTL_TOP    := mix_train_top
FILELIST   := files.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := *** PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TB_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
